//--- source/mem_pkg.sv
package mem_pkg;

    // default widths, the top level checks its parameters against these
    localparam int TAG_WIDTH  = 6;
    localparam int PREG_WIDTH = 7;

    typedef logic [31:0]           word_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;  // reorder buffer index
    typedef logic [PREG_WIDTH-1:0] preg_t; // physical destination register
    typedef logic [3:0]            sel_t;  // wishbone byte select

    // bit 3 marks a store, bits 2:0 are the RISC-V funct3
    typedef logic [3:0] mem_op_t;

    localparam mem_op_t OP_LB  = 4'b0000;
    localparam mem_op_t OP_LH  = 4'b0001;
    localparam mem_op_t OP_LW  = 4'b0010;
    localparam mem_op_t OP_LBU = 4'b0100;
    localparam mem_op_t OP_LHU = 4'b0101;
    localparam mem_op_t OP_SB  = 4'b1000;
    localparam mem_op_t OP_SH  = 4'b1001;
    localparam mem_op_t OP_SW  = 4'b1010;

    // access controller states
    typedef enum logic {
        IDLE,
        BUS
    } ctrl_state_t;

endpackage

//--- source/mem_req_queue.sv
module mem_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             push,
    input  mem_pkg::mem_op_t push_op,
    input  mem_pkg::word_t   push_addr,
    input  mem_pkg::word_t   push_wdata,
    input  mem_pkg::tag_t    push_tag,
    input  mem_pkg::preg_t   push_dest,
    input  logic             pop,
    output logic             full,
    output logic             empty,
    output mem_pkg::mem_op_t head_op,
    output mem_pkg::word_t   head_addr,
    output mem_pkg::word_t   head_wdata,
    output mem_pkg::tag_t    head_tag,
    output mem_pkg::preg_t   head_dest
);
    localparam int AW = $clog2(QUEUE_DEPTH);

    mem_pkg::mem_op_t op_mem    [QUEUE_DEPTH];
    mem_pkg::word_t   addr_mem  [QUEUE_DEPTH];
    mem_pkg::word_t   wdata_mem [QUEUE_DEPTH];
    mem_pkg::tag_t    tag_mem   [QUEUE_DEPTH];
    mem_pkg::preg_t   dest_mem  [QUEUE_DEPTH];

    logic [AW:0] wr_ptr; // extra msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        do_push;

    if (QUEUE_DEPTH < 2 || (1 << AW) != QUEUE_DEPTH) begin : g_depth_check
        $error("mem_req_queue: QUEUE_DEPTH must be a power of two, at least 2");
    end

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_push = push && !full && !flush; // a request in a flush cycle is lost

    // pointers
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            op_mem[wr_ptr[AW-1:0]]    <= push_op;
            addr_mem[wr_ptr[AW-1:0]]  <= push_addr;
            wdata_mem[wr_ptr[AW-1:0]] <= push_wdata;
            tag_mem[wr_ptr[AW-1:0]]   <= push_tag;
            dest_mem[wr_ptr[AW-1:0]]  <= push_dest;
        end
    end

    assign head_op    = op_mem[rd_ptr[AW-1:0]];
    assign head_addr  = addr_mem[rd_ptr[AW-1:0]];
    assign head_wdata = wdata_mem[rd_ptr[AW-1:0]];
    assign head_tag   = tag_mem[rd_ptr[AW-1:0]];
    assign head_dest  = dest_mem[rd_ptr[AW-1:0]];

    // the requester has to honour full, the controller has to honour empty
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("mem_req_queue: push while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("mem_req_queue: pop while empty");

endmodule

//--- source/mem_access_ctrl.sv
module mem_access_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             q_empty,
    input  mem_pkg::mem_op_t q_op,
    input  mem_pkg::word_t   q_addr,
    input  mem_pkg::word_t   q_wdata,
    input  mem_pkg::tag_t    q_tag,
    input  mem_pkg::preg_t   q_dest,
    input  mem_pkg::word_t   wb_dat_r,
    input  logic             wb_ack,
    output logic             q_pop,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output mem_pkg::word_t   wb_adr,
    output mem_pkg::sel_t    wb_sel,
    output mem_pkg::word_t   wb_dat_w,
    output logic             acc_done,
    output mem_pkg::mem_op_t acc_op,
    output logic [1:0]       acc_offset,
    output mem_pkg::tag_t    acc_tag,
    output mem_pkg::preg_t   acc_dest,
    output mem_pkg::word_t   acc_rdata
);
    mem_pkg::ctrl_state_t state;
    mem_pkg::mem_op_t     lat_op;
    mem_pkg::word_t       lat_addr;
    mem_pkg::word_t       lat_wdata;
    mem_pkg::tag_t        lat_tag;
    mem_pkg::preg_t       lat_dest;
    logic                 discard; // response of this access is garbage
    logic                 is_byte;
    logic                 is_half;
    logic                 is_word;

    assign q_pop = (state == mem_pkg::IDLE) && !q_empty && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mem_pkg::IDLE;
            wb_stb  <= 1'b0;
            discard <= 1'b0;
        end else begin
            case (state)
                mem_pkg::IDLE: begin
                    if (q_pop) begin
                        state   <= mem_pkg::BUS;
                        wb_stb  <= 1'b1;
                        discard <= 1'b0;
                    end
                end
                mem_pkg::BUS: begin
                    if (flush) begin
                        discard <= 1'b1; // still finish the cycle on the bus
                    end
                    if (wb_ack) begin
                        state  <= mem_pkg::IDLE;
                        wb_stb <= 1'b0;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    // head entry captured at the pop
    always_ff @(posedge clk) begin
        if (q_pop) begin
            lat_op    <= q_op;
            lat_addr  <= q_addr;
            lat_wdata <= q_wdata;
            lat_tag   <= q_tag;
            lat_dest  <= q_dest;
        end
    end

    // access size
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        case (lat_op)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: is_byte = 1'b1;
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: is_half = 1'b1;
            mem_pkg::OP_LW, mem_pkg::OP_SW:                  is_word = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        if (is_byte) begin
            wb_sel   = 4'b0001 << lat_addr[1:0];
            wb_dat_w = {4{lat_wdata[7:0]}}; // byte on every lane
        end else if (is_half) begin
            wb_sel   = 4'b0011 << lat_addr[1:0];
            wb_dat_w = {2{lat_wdata[15:0]}};
        end else begin
            wb_sel   = 4'b1111;
            wb_dat_w = lat_wdata;
        end
    end

    assign wb_cyc = (state == mem_pkg::BUS);
    assign wb_we  = lat_op[3];
    assign wb_adr = {lat_addr[31:2], 2'b00}; // word aligned

    // a flush in the ack cycle also kills the response
    assign acc_done   = wb_cyc && wb_ack && !discard && !flush;
    assign acc_op     = lat_op;
    assign acc_offset = lat_addr[1:0];
    assign acc_tag    = lat_tag;
    assign acc_dest   = lat_dest;
    assign acc_rdata  = wb_dat_r;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("mem_access_ctrl: stb without cyc");

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        wb_cyc |-> !(is_half && lat_addr[0]) && !(is_word && lat_addr[1:0] != 2'b00))
        else $error("mem_access_ctrl: misaligned access");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_sel)
            && $stable(wb_we) && $stable(wb_dat_w))
        else $error("mem_access_ctrl: bus outputs changed before ack");

endmodule

//--- source/mem_writeback.sv
module mem_writeback (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             acc_done,
    input  mem_pkg::mem_op_t acc_op,
    input  logic [1:0]       acc_offset,
    input  mem_pkg::tag_t    acc_tag,
    input  mem_pkg::preg_t   acc_dest,
    input  mem_pkg::word_t   acc_rdata,
    output logic             res_valid,
    output logic             res_store,
    output mem_pkg::tag_t    res_tag,
    output mem_pkg::preg_t   res_dest,
    output mem_pkg::word_t   res_data
);
    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;
    mem_pkg::word_t load_data;

    assign byte_sel = acc_rdata[8*acc_offset +: 8];
    assign half_sel = acc_rdata[16*acc_offset[1] +: 16]; // offset is even here

    // extension by funct3
    always_comb begin
        case (acc_op)
            mem_pkg::OP_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
            mem_pkg::OP_LBU: load_data = {24'b0, byte_sel};
            mem_pkg::OP_LH:  load_data = {{16{half_sel[15]}}, half_sel};
            mem_pkg::OP_LHU: load_data = {16'b0, half_sel};
            mem_pkg::OP_LW:  load_data = acc_rdata;
            default:         load_data = '0; // stores broadcast zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= acc_done; // single cycle per access
        end
    end

    always_ff @(posedge clk) begin
        if (acc_done) begin
            res_store <= acc_op[3];
            res_tag   <= acc_tag;
            res_dest  <= acc_dest;
            res_data  <= load_data;
        end
    end

endmodule

//--- source/mem_unit.sv
module mem_unit #(
    parameter int TAG_WIDTH   = mem_pkg::TAG_WIDTH,
    parameter int PREG_WIDTH  = mem_pkg::PREG_WIDTH,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_pkg::mem_op_t      req_op,
    input  mem_pkg::word_t        req_addr,
    input  mem_pkg::word_t        req_wdata,
    input  logic [TAG_WIDTH-1:0]  req_tag,
    input  logic [PREG_WIDTH-1:0] req_dest,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output mem_pkg::word_t        wb_adr,
    output mem_pkg::sel_t         wb_sel,
    output mem_pkg::word_t        wb_dat_w,
    input  mem_pkg::word_t        wb_dat_r,
    input  logic                  wb_ack,
    output logic                  res_valid,
    output logic                  res_store,
    output logic [TAG_WIDTH-1:0]  res_tag,
    output logic [PREG_WIDTH-1:0] res_dest,
    output mem_pkg::word_t        res_data
);
    logic                  q_full;
    logic                  q_empty;
    logic                  q_pop;
    mem_pkg::mem_op_t      q_op;
    mem_pkg::word_t        q_addr;
    mem_pkg::word_t        q_wdata;
    logic [TAG_WIDTH-1:0]  q_tag;
    logic [PREG_WIDTH-1:0] q_dest;

    logic                  acc_done;
    mem_pkg::mem_op_t      acc_op;
    logic [1:0]            acc_offset;
    logic [TAG_WIDTH-1:0]  acc_tag;
    logic [PREG_WIDTH-1:0] acc_dest;
    mem_pkg::word_t        acc_rdata;

    // the submodules carry tags and registers as package types
    if (TAG_WIDTH != $bits(mem_pkg::tag_t)) begin : g_tag_check
        $error("mem_unit: TAG_WIDTH does not match mem_pkg::tag_t");
    end
    if (PREG_WIDTH != $bits(mem_pkg::preg_t)) begin : g_preg_check
        $error("mem_unit: PREG_WIDTH does not match mem_pkg::preg_t");
    end

    assign req_ready = !q_full;

    mem_req_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) req_queue_i (
        .clk(clk), .rst(rst), .flush(flush),
        .push(req_valid && req_ready),
        .push_op(req_op), .push_addr(req_addr), .push_wdata(req_wdata),
        .push_tag(req_tag), .push_dest(req_dest),
        .pop(q_pop), .full(q_full), .empty(q_empty),
        .head_op(q_op), .head_addr(q_addr), .head_wdata(q_wdata),
        .head_tag(q_tag), .head_dest(q_dest)
    );

    mem_access_ctrl access_ctrl_i (
        .clk(clk), .rst(rst), .flush(flush),
        .q_empty(q_empty), .q_op(q_op), .q_addr(q_addr), .q_wdata(q_wdata),
        .q_tag(q_tag), .q_dest(q_dest), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .q_pop(q_pop), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w),
        .acc_done(acc_done), .acc_op(acc_op), .acc_offset(acc_offset),
        .acc_tag(acc_tag), .acc_dest(acc_dest), .acc_rdata(acc_rdata)
    );

    mem_writeback writeback_i (
        .clk(clk), .rst(rst), .flush(flush),
        .acc_done(acc_done), .acc_op(acc_op), .acc_offset(acc_offset),
        .acc_tag(acc_tag), .acc_dest(acc_dest), .acc_rdata(acc_rdata),
        .res_valid(res_valid), .res_store(res_store), .res_tag(res_tag),
        .res_dest(res_dest), .res_data(res_data)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk; // 4 ns period

endmodule

//--- test/wb_mem_model.sv
module wb_mem_model #(
    parameter int WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [3:0]  sel,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW = $clog2(WORDS);

    logic [31:0]   mem [WORDS];
    integer        seed = 32'hef8d_ebcc;
    int            wait_left; // wait states still to go
    int            wait_now;
    logic          active;
    logic [AW-1:0] idx;

    assign idx = adr[AW+1:2];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);
        end
    end

    // registered ack after 0 to 3 wait states
    always @(posedge clk) begin
        if (rst) begin
            ack    <= 1'b0;
            active <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                wait_now = active ? wait_left : $unsigned($random(seed)) % 4;
                if (wait_now == 0) begin
                    ack    <= 1'b1;
                    active <= 1'b0;
                    dat_r  <= mem[idx];
                    if (we) begin
                        for (int k = 0; k < 4; k++) begin
                            if (sel[k]) begin
                                mem[idx][8*k +: 8] <= dat_w[8*k +: 8];
                            end
                        end
                    end
                end else begin
                    active    <= 1'b1;
                    wait_left <= wait_now - 1;
                end
            end
        end
    end

endmodule

//--- test/mem_unit_tb.sv
module mem_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200; // cycles allowed per wait

    logic        clk;
    logic        rst;
    logic        flush;
    logic        req_valid;
    logic        req_ready;
    logic [3:0]  req_op;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [5:0]  req_tag;
    logic [6:0]  req_dest;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        res_valid;
    logic        res_store;
    logic [5:0]  res_tag;
    logic [6:0]  res_dest;
    logic [31:0] res_data;

    int          errors = 0;
    int          checks = 0;
    integer      seed = 32'hef8d_ebcc;
    logic [5:0]  next_tag = 6'd1;

    // expected and observed results, in order
    logic        exp_store [$];
    logic [5:0]  exp_tag [$];
    logic [6:0]  exp_dest [$];
    logic [31:0] exp_data [$];
    logic        got_store [$];
    logic [5:0]  got_tag [$];
    logic [6:0]  got_dest [$];
    logic [31:0] got_data [$];

    tb_clock clock_i (.clk(clk));

    wb_mem_model #(.WORDS(64)) mem_model_i (
        .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .sel(wb_sel), .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack)
    );

    mem_unit #(.TAG_WIDTH(6), .PREG_WIDTH(7), .QUEUE_DEPTH(4)) mem_unit_i (
        .clk(clk), .rst(rst), .flush(flush),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_tag(req_tag), .req_dest(req_dest),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_sel(wb_sel),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .res_valid(res_valid), .res_store(res_store), .res_tag(res_tag),
        .res_dest(res_dest), .res_data(res_data)
    );

    // result bus monitor, values of the cycle before the edge
    always @(posedge clk) begin
        if (!rst && res_valid) begin
            got_store.push_back(res_store);
            got_tag.push_back(res_tag);
            got_dest.push_back(res_dest);
            got_data.push_back(res_data);
        end
    end

    // bus address stays word aligned for every access
    always @(posedge clk) begin
        if (!rst && wb_cyc) begin
            check("wb_adr[1:0]", 0, wb_adr[1:0]);
        end
    end

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort(input string what);
        $display("Timeout: %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic preload(input logic [31:0] addr, input logic [31:0] value);
        mem_model_i.mem[addr[7:2]] = value;
    endtask

    // load result from the RISC-V extension rules
    function automatic logic [31:0] load_value(input logic [3:0] op, input logic [31:0] word,
                                               input logic [1:0] off);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op[2:0])
            3'b000:  return {{24{sh[7]}}, sh[7:0]};
            3'b100:  return {24'h0, sh[7:0]};
            3'b001:  return {{16{sh[15]}}, sh[15:0]};
            3'b101:  return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    // memory word after a store, lanes picked by the byte select
    function automatic logic [31:0] store_merge(input logic [31:0] word, input logic [3:0] op,
                                                input logic [1:0] off, input logic [31:0] data);
        logic [3:0]  sel;
        logic [31:0] res;
        sel = (op[1:0] == 2'b00) ? 4'b0001 : (op[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        sel = sel << off;
        res = word;
        for (int k = 0; k < 4; k++) begin
            if (sel[k]) begin
                res[8*k +: 8] = data[8*(k - off) +: 8];
            end
        end
        return res;
    endfunction

    task automatic send(input logic [3:0] op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [31:0] data);
        int n;
        n = 0;
        while (!req_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                abort("req_ready stayed low");
            end
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_tag   = next_tag;
        req_dest  = {1'b1, next_tag};
        @(posedge clk); // accepted here
        #1;
        req_valid = 1'b0;
        exp_store.push_back(op[3]);
        exp_tag.push_back(next_tag);
        exp_dest.push_back({1'b1, next_tag});
        exp_data.push_back(op[3] ? 32'h0 : data);
        next_tag++;
    endtask

    task automatic drain_results();
        int   n;
        logic st;
        while (exp_tag.size() > 0) begin
            n = 0;
            while (got_tag.size() == 0) begin
                @(posedge clk);
                #1;
                n++;
                if (n > TIMEOUT) begin
                    abort("no result appeared on the result bus");
                end
            end
            st = exp_store.pop_front();
            check("res_store", st, got_store.pop_front());
            check("res_tag", exp_tag.pop_front(), got_tag.pop_front());
            if (!st) begin
                check("res_dest", exp_dest.pop_front(), got_dest.pop_front());
            end else begin
                void'(exp_dest.pop_front()); // no destination for stores
                void'(got_dest.pop_front());
            end
            check("res_data", exp_data.pop_front(), got_data.pop_front());
        end
        repeat (2) @(posedge clk); // a repeated res_valid would show up here
        #1;
        check("extra results", 0, got_tag.size());
    endtask

    task automatic test_reset();
        check("wb_cyc after reset", 0, wb_cyc);
        check("wb_stb after reset", 0, wb_stb);
        check("res_valid after reset", 0, res_valid);
        check("req_ready after reset", 1, req_ready);
    endtask

    task automatic test_word();
        send(mem_pkg::OP_SW, 32'h10, 32'hdead_beef, 0);
        send(mem_pkg::OP_LW, 32'h10, 32'h0, 32'hdead_beef);
        drain_results();
    endtask

    task automatic test_subword_loads();
        logic [31:0] word;
        word = 32'h80f1_7f82;
        preload(32'h20, word);
        for (int off = 0; off < 4; off++) begin
            send(mem_pkg::OP_LB, 32'h20 + off, 32'h0, load_value(mem_pkg::OP_LB, word, off));
            send(mem_pkg::OP_LBU, 32'h20 + off, 32'h0, load_value(mem_pkg::OP_LBU, word, off));
            if (off % 2 == 0) begin
                send(mem_pkg::OP_LH, 32'h20 + off, 32'h0, load_value(mem_pkg::OP_LH, word, off));
                send(mem_pkg::OP_LHU, 32'h20 + off, 32'h0,
                     load_value(mem_pkg::OP_LHU, word, off));
            end
        end
        drain_results();
    endtask

    task automatic test_subword_stores();
        logic [31:0] word;
        word = 32'h1122_3344;
        preload(32'h30, word);
        send(mem_pkg::OP_SB, 32'h31, 32'h0000_00a5, 0);
        word = store_merge(word, mem_pkg::OP_SB, 1, 32'h0000_00a5);
        send(mem_pkg::OP_SH, 32'h32, 32'h5555_beef, 0); // upper half must not land
        word = store_merge(word, mem_pkg::OP_SH, 2, 32'h5555_beef);
        send(mem_pkg::OP_SB, 32'h30, 32'h0000_1277, 0);
        word = store_merge(word, mem_pkg::OP_SB, 0, 32'h0000_1277);
        send(mem_pkg::OP_LW, 32'h30, 32'h0, word);
        send(mem_pkg::OP_SH, 32'h30, 32'h0000_c3d2, 0);
        word = store_merge(word, mem_pkg::OP_SH, 0, 32'h0000_c3d2);
        send(mem_pkg::OP_SB, 32'h33, 32'h0000_0009, 0);
        word = store_merge(word, mem_pkg::OP_SB, 3, 32'h0000_0009);
        send(mem_pkg::OP_LW, 32'h30, 32'h0, word);
        drain_results();
    endtask

    task automatic test_ordering();
        logic [31:0] vals [8];
        for (int i = 0; i < 8; i++) begin
            vals[i] = $random(seed);
            send(mem_pkg::OP_SW, 32'h40 + 4 * i, vals[i], 0);
        end
        for (int i = 0; i < 8; i++) begin
            send(mem_pkg::OP_LW, 32'h40 + 4 * i, 32'h0, vals[i]);
        end
        drain_results();
    endtask

    task automatic test_flush();
        int n;
        preload(32'h84, 32'h0bad_cafe);
        send(mem_pkg::OP_LW, 32'h80, 32'h0, 0);
        send(mem_pkg::OP_LW, 32'h84, 32'h0, 0);
        send(mem_pkg::OP_LHU, 32'h88, 32'h0, 0);
        n = 0;
        while (!wb_cyc) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                abort("the bus never started an access");
            end
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        exp_store.delete(); // everything pending is killed
        exp_tag.delete();
        exp_dest.delete();
        exp_data.delete();
        n = 0;
        while (wb_cyc) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                abort("the flushed access never finished");
            end
        end
        repeat (3) @(posedge clk);
        #1;
        check("results after flush", 0, got_tag.size());
        send(mem_pkg::OP_LW, 32'h84, 32'h0, 32'h0bad_cafe);
        drain_results();
    endtask

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req_op    = '0;
        req_addr  = '0;
        req_wdata = '0;
        req_tag   = '0;
        req_dest  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_word();
        test_subword_loads();
        test_subword_stores();
        test_ordering();
        test_flush();
        finish_run();
    end

endmodule

//--- verilog.f
source/mem_pkg.sv
source/mem_req_queue.sv
source/mem_access_ctrl.sv
source/mem_writeback.sv
source/mem_unit.sv
test/tb_clock.sv
test/wb_mem_model.sv
test/mem_unit_tb.sv

//--- Bender.yml
package:
  name: mem_unit

sources:
  - source/mem_pkg.sv
  - source/mem_req_queue.sv
  - source/mem_access_ctrl.sv
  - source/mem_writeback.sv
  - source/mem_unit.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/wb_mem_model.sv
      - test/mem_unit_tb.sv
